/* sources.f */
+incdir+include
hdl/dft_pkg.sv
hdl/mrd_dft_rdx3.sv
hdl/dft_rdx2.sv
hdl/frame_buffer.sv
hdl/dft6_ctrl.sv
hdl/dft6_top.sv
verif/dft6_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the dft6 testbench with Verilator, then judge the run by its log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module dft6_tb \
	-o dft6_sim > build.log 2>&1 \
	&& ./obj_dir/dft6_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log 2>/dev/null \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* include/dft6_model.svh */
`ifndef DFT6_MODEL_SVH
`define DFT6_MODEL_SVH

// two's complement wrap to w bits
function automatic longint dft6_wrap(input longint v, input int w);
	longint m;
	m = v & ((longint'(1) << w) - 1);
	if (m[w-1])
		m = m - (longint'(1) << w);
	return m;
endfunction

// 2 x 3 prime-factor DFT, same rounding as the RTL
function automatic void dft6_model(input longint xr [6], input longint xi [6], input int w,
		output longint yr [6], output longint yi [6]);
	longint tr [6];
	longint ti [6];
	longint ur, ui, sr, si, dr, di, mr, mi, rr, ri;
	int p0, p1, p2;
	for (int n1 = 0; n1 < 2; n1++) begin
		p0 = (3 * n1) % 6;
		p1 = (3 * n1 + 2) % 6;
		p2 = (3 * n1 + 4) % 6;
		sr = dft6_wrap(xr[p1] + xr[p2], w);
		si = dft6_wrap(xi[p1] + xi[p2], w);
		dr = dft6_wrap(xr[p2] - xr[p1], w);
		di = dft6_wrap(xi[p2] - xi[p1], w);
		mr = dft6_wrap(xr[p0] - sr / 2, w); // toward zero
		mi = dft6_wrap(xi[p0] - si / 2, w);
		rr = dft6_wrap((-di * 14189) >>> 14, w);
		ri = dft6_wrap((dr * 14189) >>> 14, w);
		tr[p0] = dft6_wrap(xr[p0] + sr, w);
		ti[p0] = dft6_wrap(xi[p0] + si, w);
		tr[p1] = dft6_wrap(mr + rr, w);
		ti[p1] = dft6_wrap(mi + ri, w);
		tr[p2] = dft6_wrap(mr - rr, w);
		ti[p2] = dft6_wrap(mi - ri, w);
	end
	for (int k2 = 0; k2 < 3; k2++) begin
		p0 = (2 * k2) % 6;
		p1 = (3 + 2 * k2) % 6;
		ur = tr[p0];
		ui = ti[p0];
		tr[p0] = dft6_wrap(ur + tr[p1], w);
		ti[p0] = dft6_wrap(ui + ti[p1], w);
		tr[p1] = dft6_wrap(ur - tr[p1], w);
		ti[p1] = dft6_wrap(ui - ti[p1], w);
	end
	for (int k = 0; k < 6; k++) begin
		yr[k] = tr[(3 * (k % 2) + 2 * (k % 3)) % 6];
		yi[k] = ti[(3 * (k % 2) + 2 * (k % 3)) % 6];
	end
endfunction

`endif

/* verif/dft6_tb.sv */
`timescale 1ns/1ns
module dft6_tb;

`include "dft6_model.svh"

localparam int W = 24;
localparam int TMO = 200; // cycles allowed per handshake wait

logic clk;
logic rst_n;
logic in_req;
logic in_ack;
logic signed [W-1:0] in_real;
logic signed [W-1:0] in_imag;
logic out_req;
logic out_ack;
logic signed [W-1:0] out_real;
logic signed [W-1:0] out_imag;

int err_cnt;
int test_cnt;
int fail_cnt;
int proto_err;
logic prev_in_req;
logic prev_in_ack;
logic prev_out_req;
logic prev_out_ack;

dft6_top #(.wDataInOut(W)) dft6_top_i (
	.clk(clk), .rst_n(rst_n),
	.in_req(in_req), .in_ack(in_ack), .in_real(in_real), .in_imag(in_imag),
	.out_req(out_req), .out_ack(out_ack), .out_real(out_real), .out_imag(out_imag)
);

initial begin
	clk = 1'b0;
	forever #50 clk = ~clk;
end

// four-phase order on both ports
always @(posedge clk) begin
	if (rst_n) begin
		if (in_ack && !prev_in_ack && !prev_in_req) begin
			$display("protocol error: in_ack rose while in_req was low");
			proto_err++;
		end
		if (!out_req && prev_out_req && !prev_out_ack) begin
			$display("protocol error: out_req fell before out_ack rose");
			proto_err++;
		end
	end
	prev_in_req <= in_req;
	prev_in_ack <= in_ack;
	prev_out_req <= out_req;
	prev_out_ack <= out_ack;
end

function automatic longint rand_part();
	return longint'($urandom_range(32'd1048576, 32'd0)) - 64'sd524288; // +-2^19
endfunction

task automatic wait_for(input bit is_out, input logic level, input string what);
	int n;
	n = 0;
	do begin
		@(posedge clk);
		n++;
	end while ((is_out ? out_req : in_ack) != level && n < TMO);
	if ((is_out ? out_req : in_ack) != level) begin
		$display("timeout: %s did not reach %0b within %0d cycles", what, level, TMO);
		$display("SOME TESTS FAILED");
		$finish;
	end
endtask

task automatic send_sample(input longint re, input longint im);
	in_real <= W'(re);
	in_imag <= W'(im);
	in_req <= 1'b1;
	wait_for(1'b0, 1'b1, "in_ack");
	in_req <= 1'b0;
	wait_for(1'b0, 1'b0, "in_ack");
endtask

task automatic recv_sample(input int k, input longint exp_r, input longint exp_i, input int hold);
	logic signed [W-1:0] held_r;
	logic signed [W-1:0] held_i;
	wait_for(1'b1, 1'b1, "out_req");
	held_r = out_real;
	held_i = out_imag;
	if (longint'(out_real) != exp_r) begin
		$display("mismatch out_real X[%0d]: expected %h, got %h", k, W'(exp_r), out_real);
		err_cnt++;
	end
	if (longint'(out_imag) != exp_i) begin
		$display("mismatch out_imag X[%0d]: expected %h, got %h", k, W'(exp_i), out_imag);
		err_cnt++;
	end
	repeat (hold) begin
		@(posedge clk);
		if (out_real !== held_r || out_imag !== held_i) begin
			$display("mismatch out_real/out_imag X[%0d] under back-pressure: held %h/%h, now %h/%h",
				k, held_r, held_i, out_real, out_imag);
			err_cnt++;
		end
	end
	out_ack <= 1'b1;
	wait_for(1'b1, 1'b0, "out_req");
	out_ack <= 1'b0;
endtask

task automatic run_frame(input longint xr [6], input longint xi [6], input int max_hold);
	longint er [6];
	longint ei [6];
	dft6_model(xr, xi, W, er, ei);
	for (int n = 0; n < 6; n++)
		send_sample(xr[n], xi[n]);
	for (int k = 0; k < 6; k++)
		recv_sample(k, er[k], ei[k], (max_hold > 0) ? int'($urandom_range(max_hold, 0)) : 0);
endtask

task automatic finish_test(input string name, input int err_before);
	test_cnt++;
	if (err_cnt != err_before) begin
		fail_cnt++;
		$display("test %s: failed with %0d errors", name, err_cnt - err_before);
	end else begin
		$display("test %s: ok", name);
	end
endtask

initial begin
	longint xr [6];
	longint xi [6];
	longint er [6];
	longint ei [6];
	longint sgn;
	int base;
	err_cnt = 0;
	test_cnt = 0;
	fail_cnt = 0;
	proto_err = 0;
	void'($urandom(32'he9de_ce89));
	rst_n = 1'b0;
	in_req = 1'b0;
	in_real = '0;
	in_imag = '0;
	out_ack = 1'b0;
	repeat (16) @(posedge clk);
	rst_n <= 1'b1;

	base = err_cnt;
	@(posedge clk);
	if (in_ack !== 1'b0) begin
		$display("mismatch in_ack after reset: expected %h, got %h", 1'b0, in_ack);
		err_cnt++;
	end
	if (out_req !== 1'b0) begin
		$display("mismatch out_req after reset: expected %h, got %h", 1'b0, out_req);
		err_cnt++;
	end
	finish_test("reset", base);

	base = err_cnt;
	for (int n = 0; n < 6; n++) begin
		xr[n] = 0;
		xi[n] = 0;
	end
	xr[0] = 1000;
	xi[0] = -500;
	dft6_model(xr, xi, W, er, ei);
	for (int k = 0; k < 6; k++) begin
		if (er[k] != 1000 || ei[k] != -500) begin
			$display("impulse at n=0 does not give a flat spectrum at X[%0d]", k);
			err_cnt++;
		end
	end
	run_frame(xr, xi, 0);
	xr[0] = 0;
	xi[0] = 0;
	xr[3] = 1000;
	xi[3] = -500;
	dft6_model(xr, xi, W, er, ei);
	for (int k = 0; k < 6; k++) begin
		sgn = (k % 2 == 1) ? -1 : 1; // (-1)^k
		if (er[k] != sgn * 1000 || ei[k] != sgn * -500) begin
			$display("impulse at n=3 does not alternate in sign at X[%0d]", k);
			err_cnt++;
		end
	end
	run_frame(xr, xi, 0);
	finish_test("impulse", base);

	base = err_cnt;
	repeat (60) begin
		for (int n = 0; n < 6; n++) begin
			xr[n] = rand_part();
			xi[n] = rand_part();
		end
		run_frame(xr, xi, 0);
	end
	finish_test("random", base);

	base = err_cnt;
	repeat (20) begin
		for (int n = 0; n < 6; n++) begin
			xr[n] = rand_part();
			xi[n] = rand_part();
		end
		run_frame(xr, xi, 20);
	end
	finish_test("backpressure", base);

	base = err_cnt;
	for (int n = 0; n < 6; n++) begin
		xr[n] = 123457;
		xi[n] = -98765;
	end
	dft6_model(xr, xi, W, er, ei);
	if (er[0] != 6 * 123457 || ei[0] != 6 * -98765) begin
		$display("constant frame does not give X[0] = 6c");
		err_cnt++;
	end
	run_frame(xr, xi, 0);
	finish_test("constant", base);

	base = err_cnt;
	err_cnt += proto_err;
	finish_test("protocol", base);

	$display("tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
	if (fail_cnt == 0) begin
		$display("ALL TESTS PASSED");
	end else begin
		$display("SOME TESTS FAILED");
	end
	$finish;
end

endmodule

/* hdl/dft6_top.sv */
`timescale 1ns/1ns
module dft6_top import dft_pkg::*; #(
	parameter wDataInOut = 30
) (
	input  logic clk,
	input  logic rst_n,

	input  logic in_req,
	output logic in_ack,
	input  logic signed [wDataInOut-1:0] in_real,
	input  logic signed [wDataInOut-1:0] in_imag,

	output logic out_req,
	input  logic out_ack,
	output logic signed [wDataInOut-1:0] out_real,
	output logic signed [wDataInOut-1:0] out_imag
);

ctrl_state_e state;
logic wr_en;
logic wb_en;
logic rdx3_val;
logic rdx3_done;
logic rdx2_val;
logic rdx2_done;
logic [2:0] wr_idx;
logic [2:0] out_idx;
logic [1:0] rd_grp;
logic [1:0] wb_grp;

logic signed [wDataInOut-1:0] r3_real [0:2];
logic signed [wDataInOut-1:0] r3_imag [0:2];
logic signed [wDataInOut-1:0] y3_real [0:2];
logic signed [wDataInOut-1:0] y3_imag [0:2];
logic signed [wDataInOut-1:0] u_real;
logic signed [wDataInOut-1:0] u_imag;
logic signed [wDataInOut-1:0] v_real;
logic signed [wDataInOut-1:0] v_imag;
logic signed [wDataInOut-1:0] z0_real;
logic signed [wDataInOut-1:0] z0_imag;
logic signed [wDataInOut-1:0] z1_real;
logic signed [wDataInOut-1:0] z1_imag;

dft6_ctrl dft6_ctrl_i (
	.clk(clk), .rst_n(rst_n),
	.in_req(in_req), .in_ack(in_ack), .out_req(out_req), .out_ack(out_ack),
	.state(state), .wr_en(wr_en), .wr_idx(wr_idx), .rd_grp(rd_grp),
	.rdx3_val(rdx3_val), .rdx3_done(rdx3_done),
	.rdx2_val(rdx2_val), .rdx2_done(rdx2_done),
	.wb_en(wb_en), .wb_grp(wb_grp), .out_idx(out_idx)
);

frame_buffer #(.wDataInOut(wDataInOut)) frame_buffer_i (
	.clk(clk), .rst_n(rst_n), .state(state),
	.wr_en(wr_en), .wr_idx(wr_idx), .wr_real(in_real), .wr_imag(in_imag),
	.rd_grp(rd_grp), .r3_real(r3_real), .r3_imag(r3_imag),
	.r2_u_real(u_real), .r2_u_imag(u_imag), .r2_v_real(v_real), .r2_v_imag(v_imag),
	.wb_en(wb_en), .wb_grp(wb_grp), .wb3_real(y3_real), .wb3_imag(y3_imag),
	.wb2_z0_real(z0_real), .wb2_z0_imag(z0_imag),
	.wb2_z1_real(z1_real), .wb2_z1_imag(z1_imag),
	.out_idx(out_idx), .out_real(out_real), .out_imag(out_imag)
);

mrd_dft_rdx3 #(.wDataInOut(wDataInOut)) mrd_dft_rdx3_i (
	.clk(clk), .rst_n(rst_n), .in_val(rdx3_val),
	.din_real(r3_real), .din_imag(r3_imag),
	.out_val(rdx3_done), .dout_real(y3_real), .dout_imag(y3_imag)
);

dft_rdx2 #(.wDataInOut(wDataInOut)) dft_rdx2_i (
	.clk(clk), .rst_n(rst_n), .in_val(rdx2_val),
	.u_real(u_real), .u_imag(u_imag), .v_real(v_real), .v_imag(v_imag),
	.out_val(rdx2_done), .z0_real(z0_real), .z0_imag(z0_imag),
	.z1_real(z1_real), .z1_imag(z1_imag)
);

endmodule

/* hdl/dft6_ctrl.sv */
`timescale 1ns/1ns
module dft6_ctrl import dft_pkg::*; (
	input  logic clk,
	input  logic rst_n,

	input  logic in_req,
	output logic in_ack,
	output logic out_req,
	input  logic out_ack,

	output ctrl_state_e state,
	output logic wr_en,
	output logic [2:0] wr_idx,
	output logic [1:0] rd_grp,
	output logic rdx3_val,
	input  logic rdx3_done,
	output logic rdx2_val,
	input  logic rdx2_done,
	output logic wb_en,
	output logic [1:0] wb_grp,
	output logic [2:0] out_idx
);

logic [2:0] smp_cnt; // samples stored
logic [1:0] iss_cnt; // groups sent to a butterfly
logic [1:0] ret_cnt; // groups written back

assign wr_idx = smp_cnt;
assign rd_grp = iss_cnt;
assign wb_grp = ret_cnt;

assign wr_en = (state == ST_LOAD) && in_req && !in_ack;
assign rdx3_val = (state == ST_RDX3) && (iss_cnt != 2'd2);
assign rdx2_val = (state == ST_RDX2) && (iss_cnt != 2'd3);
assign wb_en = ((state == ST_RDX3) && rdx3_done) || ((state == ST_RDX2) && rdx2_done);

always_ff @(posedge clk) begin
	if (!rst_n) begin
		state <= ST_IDLE;
		in_ack <= 1'b0;
		out_req <= 1'b0;
		smp_cnt <= '0;
		iss_cnt <= '0;
		ret_cnt <= '0;
		out_idx <= '0;
	end else begin
		case (state)
		ST_IDLE: begin
			smp_cnt <= '0;
			state <= ST_LOAD;
		end
		ST_LOAD: begin
			if (in_req && !in_ack) begin
				in_ack <= 1'b1; // sample written this edge
			end else if (!in_req && in_ack) begin
				in_ack <= 1'b0;
				if (smp_cnt == 3'd5) begin
					iss_cnt <= '0;
					ret_cnt <= '0;
					state <= ST_RDX3;
				end else begin
					smp_cnt <= smp_cnt + 3'd1;
				end
			end
		end
		ST_RDX3: begin
			if (rdx3_val)
				iss_cnt <= iss_cnt + 2'd1;
			if (rdx3_done) begin
				if (ret_cnt == 2'd1) begin
					iss_cnt <= '0;
					ret_cnt <= '0;
					state <= ST_RDX2;
				end else begin
					ret_cnt <= ret_cnt + 2'd1;
				end
			end
		end
		ST_RDX2: begin
			if (rdx2_val)
				iss_cnt <= iss_cnt + 2'd1;
			if (rdx2_done) begin
				if (ret_cnt == 2'd2) begin
					out_idx <= '0;
					out_req <= 1'b1; // X[0] slot already final
					state <= ST_UNLOAD;
				end else begin
					ret_cnt <= ret_cnt + 2'd1;
				end
			end
		end
		ST_UNLOAD: begin
			if (out_req && out_ack) begin
				out_req <= 1'b0;
			end else if (!out_req && !out_ack) begin
				if (out_idx == 3'd5) begin
					state <= ST_IDLE;
				end else begin
					out_idx <= out_idx + 3'd1;
					out_req <= 1'b1;
				end
			end
		end
		default: state <= ST_IDLE;
		endcase
	end
end

a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
	$rose(in_ack) |-> $past(in_req));

endmodule

/* hdl/frame_buffer.sv */
`timescale 1ns/1ns
module frame_buffer import dft_pkg::*; #(
	parameter wDataInOut = 30
) (
	input  logic clk,
	input  logic rst_n,
	input  ctrl_state_e state,

	input  logic wr_en,
	input  logic [2:0] wr_idx,
	input  logic signed [wDataInOut-1:0] wr_real,
	input  logic signed [wDataInOut-1:0] wr_imag,

	input  logic [1:0] rd_grp,
	output logic signed [wDataInOut-1:0] r3_real [0:2],
	output logic signed [wDataInOut-1:0] r3_imag [0:2],
	output logic signed [wDataInOut-1:0] r2_u_real,
	output logic signed [wDataInOut-1:0] r2_u_imag,
	output logic signed [wDataInOut-1:0] r2_v_real,
	output logic signed [wDataInOut-1:0] r2_v_imag,

	input  logic wb_en,
	input  logic [1:0] wb_grp,
	input  logic signed [wDataInOut-1:0] wb3_real [0:2],
	input  logic signed [wDataInOut-1:0] wb3_imag [0:2],
	input  logic signed [wDataInOut-1:0] wb2_z0_real,
	input  logic signed [wDataInOut-1:0] wb2_z0_imag,
	input  logic signed [wDataInOut-1:0] wb2_z1_real,
	input  logic signed [wDataInOut-1:0] wb2_z1_imag,

	input  logic [2:0] out_idx,
	output logic signed [wDataInOut-1:0] out_real,
	output logic signed [wDataInOut-1:0] out_imag
);

logic signed [wDataInOut-1:0] mem_real [0:5];
logic signed [wDataInOut-1:0] mem_imag [0:5];

// Good-Thomas slot for (radix-2 index, radix-3 index), n = 3*a + 2*b mod 6
function automatic logic [2:0] pfa_slot(input int a, input int b);
	return 3'((3 * a + 2 * b) % 6);
endfunction

always_ff @(posedge clk) begin
	if (wr_en) begin
		mem_real[wr_idx] <= wr_real;
		mem_imag[wr_idx] <= wr_imag;
	end else if (wb_en && state == ST_RDX3) begin
		for (int j = 0; j < 3; j++) begin
			mem_real[pfa_slot(wb_grp, j)] <= wb3_real[j]; // k2 order
			mem_imag[pfa_slot(wb_grp, j)] <= wb3_imag[j];
		end
	end else if (wb_en && state == ST_RDX2) begin
		mem_real[pfa_slot(0, wb_grp)] <= wb2_z0_real;
		mem_imag[pfa_slot(0, wb_grp)] <= wb2_z0_imag;
		mem_real[pfa_slot(1, wb_grp)] <= wb2_z1_real;
		mem_imag[pfa_slot(1, wb_grp)] <= wb2_z1_imag;
	end
end

always_comb begin
	for (int j = 0; j < 3; j++) begin
		r3_real[j] = mem_real[pfa_slot(rd_grp, j)];
		r3_imag[j] = mem_imag[pfa_slot(rd_grp, j)];
	end
end

assign r2_u_real = mem_real[pfa_slot(0, rd_grp)];
assign r2_u_imag = mem_imag[pfa_slot(0, rd_grp)];
assign r2_v_real = mem_real[pfa_slot(1, rd_grp)];
assign r2_v_imag = mem_imag[pfa_slot(1, rd_grp)];

// CRT output map, k1 = k mod 2 and k2 = k mod 3
assign out_real = mem_real[pfa_slot(out_idx % 2, out_idx % 3)];
assign out_imag = mem_imag[pfa_slot(out_idx % 2, out_idx % 3)];

a_no_port_clash: assert property (@(posedge clk) disable iff (!rst_n)
	!(wr_en && wb_en));

endmodule

/* hdl/dft_rdx2.sv */
`timescale 1ns/1ns
module dft_rdx2 #(
	parameter wDataInOut = 30
) (
	input  logic clk,
	input  logic rst_n,

	input  logic in_val,
	input  logic signed [wDataInOut-1:0] u_real,
	input  logic signed [wDataInOut-1:0] u_imag,
	input  logic signed [wDataInOut-1:0] v_real,
	input  logic signed [wDataInOut-1:0] v_imag,

	output logic out_val,
	output logic signed [wDataInOut-1:0] z0_real,
	output logic signed [wDataInOut-1:0] z0_imag,
	output logic signed [wDataInOut-1:0] z1_real,
	output logic signed [wDataInOut-1:0] z1_imag
);

always_ff @(posedge clk) begin
	if (!rst_n) begin
		out_val <= 1'b0;
	end else begin
		out_val <= in_val;
	end
end

always_ff @(posedge clk) begin
	z0_real <= u_real + v_real;
	z0_imag <= u_imag + v_imag;
	z1_real <= u_real - v_real; // wraps like the sum
	z1_imag <= u_imag - v_imag;
end

endmodule

/* hdl/mrd_dft_rdx3.sv */
`timescale 1ns/1ns
module mrd_dft_rdx3 import dft_pkg::*; #(
	parameter wDataInOut = 30
) (
	input  logic clk,
	input  logic rst_n,

	input  logic in_val,
	input  logic signed [wDataInOut-1:0] din_real [0:2],
	input  logic signed [wDataInOut-1:0] din_imag [0:2],

	output logic out_val,
	output logic signed [wDataInOut-1:0] dout_real [0:2],
	output logic signed [wDataInOut-1:0] dout_imag [0:2]
);

logic [2:0] val_sr;

// stage 1
logic signed [wDataInOut-1:0] a_real;
logic signed [wDataInOut-1:0] a_imag;
logic signed [wDataInOut-1:0] s_real;
logic signed [wDataInOut-1:0] s_imag;
logic signed [wDataInOut-1:0] d_real;
logic signed [wDataInOut-1:0] d_imag;

// stage 2
logic signed [wDataInOut-1:0] y0_real;
logic signed [wDataInOut-1:0] y0_imag;
logic signed [wDataInOut-1:0] m_real;
logic signed [wDataInOut-1:0] m_imag;
logic signed [PROD_W-1:0] prod_real;
logic signed [PROD_W-1:0] prod_imag;

logic signed [wDataInOut-1:0] rot_real;
logic signed [wDataInOut-1:0] rot_imag;

always_ff @(posedge clk) begin
	if (!rst_n) begin
		val_sr <= '0;
	end else begin
		val_sr <= {val_sr[1:0], in_val};
	end
end

assign out_val = val_sr[2];

always_ff @(posedge clk) begin
	a_real <= din_real[0];
	a_imag <= din_imag[0];
	s_real <= din_real[1] + din_real[2];
	s_imag <= din_imag[1] + din_imag[2];
	d_real <= din_real[2] - din_real[1];
	d_imag <= din_imag[2] - din_imag[1];

	y0_real <= a_real + s_real;
	y0_imag <= a_imag + s_imag;
	m_real <= a_real - s_real / 2; // halving truncates toward zero
	m_imag <= a_imag - s_imag / 2;
	prod_real <= d_imag * -SIN60_Q14; // j*d, real part
	prod_imag <= d_real * SIN60_Q14;

	dout_real[0] <= y0_real;
	dout_imag[0] <= y0_imag;
	dout_real[1] <= m_real + rot_real;
	dout_imag[1] <= m_imag + rot_imag;
	dout_real[2] <= m_real - rot_real;
	dout_imag[2] <= m_imag - rot_imag;
end

// floor shift, then wrap to the data width
assign rot_real = prod_real[wDataInOut+ROT_FRAC-1:ROT_FRAC];
assign rot_imag = prod_imag[wDataInOut+ROT_FRAC-1:ROT_FRAC];

a_val_latency: assert property (@(posedge clk) disable iff (!rst_n)
	out_val == $past(in_val, 3));

endmodule

/* hdl/dft_pkg.sv */
package dft_pkg;

	// controller phases, one frame at a time
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_RDX3,
		ST_RDX2,
		ST_UNLOAD
	} ctrl_state_e;

	// radix-3 rotation, sin 60 deg in Q14
	localparam logic signed [17:0] SIN60_Q14 = 18'sd14189;

	localparam int ROT_FRAC = 14; // fraction bits dropped after the multiply

	localparam int PROD_W = 48; // full rotation product

endpackage
